//--- Bender.yml
package:
  name: fft_ui_ctrl

sources:
  # package first, then leaf modules, then the top level
  - files:
      - common/fft_ui_pkg.sv
      - rtl/display/bin_to_bcd7.sv
      - rtl/display/result_display.sv
      - rtl/entry/sample_cell.sv
      - rtl/ui_mode_ctrl.sv
      - rtl/fft_ui_ctrl.sv

  - target: test
    files:
      - verification/tb_fft_ui_ctrl.sv

//--- all.f
common/fft_ui_pkg.sv
rtl/display/bin_to_bcd7.sv
rtl/display/result_display.sv
rtl/entry/sample_cell.sv
rtl/ui_mode_ctrl.sv
rtl/fft_ui_ctrl.sv
verification/tb_fft_ui_ctrl.sv

//--- common/fft_ui_pkg.sv
`default_nettype none

package fft_ui_pkg;

    // ------------------------------
    // widths and limits
    // ------------------------------
    localparam int N_SAMPLES  = 8;          // samples in, bins out
    localparam int IDX_W      = 3;
    localparam int SAMPLE_W   = 21;         // holds +-999999
    localparam int RESULT_W   = 32;
    localparam int MAX_DIGITS = 3;          // per integer / fraction part
    localparam int SCALE      = 1000;

    localparam int unsigned DISP_MAX = 9_999_999;   // largest 7-digit magnitude
    localparam int          BCD7_W   = 24;          // enough bits for DISP_MAX

    // ------------------------------
    // display codes
    // ------------------------------
    localparam logic [3:0] CODE_MINUS     = 4'hA;
    localparam logic [3:0] CODE_BLANK     = 4'hB;
    localparam logic [7:0] RESULT_DP_MASK = 8'b0001_0000;   // dp after iiii

    // ------------------------------
    // types
    // ------------------------------
    typedef enum logic [1:0] {
        MODE_INPUT    = 2'd0,
        MODE_WAIT_FFT = 2'd1,
        MODE_OUTPUT   = 2'd2
    } mode_e;

    // one decoded key event, at most one flag set
    typedef struct packed {
        logic       valid;
        logic       is_digit;
        logic       is_minus;
        logic       is_dot;
        logic       is_del;
        logic       is_next;
        logic       is_prev;
        logic       is_toggle_ri;
        logic       is_ent;
        logic       is_esc;
        logic [3:0] digit;
    } key_t;

    // named element types keep the elements signed when indexed
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [RESULT_W-1:0] result_t;

    typedef sample_t [N_SAMPLES-1:0] sample_x_t;   // FFT input bus
    typedef result_t [N_SAMPLES-1:0] bins_t;       // real or imaginary bins

endpackage

`default_nettype wire

//--- rtl/display/bin_to_bcd7.sv
`timescale 1ns/1ps
`default_nettype none

module bin_to_bcd7
    import fft_ui_pkg::*;
(
    input  wire logic              i_clk,
    input  wire logic              i_rstn,
    input  wire logic              i_start,
    input  wire logic [BCD7_W-1:0] i_val,
    output logic                   o_busy,
    output logic                   o_done,
    output logic [27:0]            o_bcd7
);

    logic [BCD7_W-1:0]             bin_sr;
    logic [27:0]                   bcd_sr;
    logic [27:0]                   bcd_adj;
    logic [$clog2(BCD7_W+1)-1:0]   bit_cnt;    // bits already shifted in

    // add 3 to every digit of 5 or more before the shift
    always_comb begin
        bcd_adj = bcd_sr;
        for (int d = 0; d < 7; d++) begin
            if (bcd_sr[4*d +: 4] >= 4'd5) begin
                bcd_adj[4*d +: 4] = bcd_sr[4*d +: 4] + 4'd3;
            end
        end
    end

    // ------------------------------
    // sequencing
    // ------------------------------
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_busy  <= 1'b0;
            o_done  <= 1'b0;
            bit_cnt <= '0;
        end else begin
            o_done <= 1'b0;
            if (!o_busy) begin
                if (i_start) begin
                    o_busy  <= 1'b1;
                    bit_cnt <= '0;
                end
            end else if (bit_cnt == BCD7_W) begin
                o_busy <= 1'b0;     // 25th edge after the start
                o_done <= 1'b1;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start && !o_busy) begin
            bin_sr <= i_val;
            bcd_sr <= '0;
        end else if (o_busy && bit_cnt != BCD7_W) begin
            {bcd_sr, bin_sr} <= {bcd_adj[26:0], bin_sr, 1'b0};  // msb first
        end
    end

    assign o_bcd7 = bcd_sr;     // holds until the next load

    a_no_restart : assert property (@(posedge i_clk) disable iff (!i_rstn)
        i_start |-> !o_busy);

endmodule

`default_nettype wire

//--- rtl/display/result_display.sv
`timescale 1ns/1ps
`default_nettype none

module result_display
    import fft_ui_pkg::*;
(
    input  wire logic             i_clk,
    input  wire logic             i_rstn,
    input  wire mode_e            i_mode,
    input  wire logic [IDX_W-1:0] i_cur_bin,
    input  wire logic             i_show_imag,
    input  wire bins_t            i_x_re,
    input  wire bins_t            i_x_im,
    output logic [31:0]           o_bcd8d,
    output logic [7:0]            o_dp_mask
);

    result_t             sel_val;
    logic                sel_neg;
    logic [RESULT_W-1:0] sel_abs;
    logic [BCD7_W-1:0]   sat_val;
    logic                launch;        // converter idle in output mode
    logic                conv_start;
    logic                conv_busy;
    logic                conv_done;
    logic [BCD7_W-1:0]   conv_val;
    logic [27:0]         conv_bcd;
    logic                req_neg;       // sign of the value being converted
    logic [27:0]         disp_bcd;
    logic                disp_neg;

    // ------------------------------
    // pick, abs, saturate
    // ------------------------------
    always_comb begin
        sel_val = i_show_imag ? i_x_im[i_cur_bin] : i_x_re[i_cur_bin];
        sel_neg = sel_val[RESULT_W-1];
        sel_abs = sel_neg ? RESULT_W'(-sel_val) : RESULT_W'(sel_val);
        sat_val = (sel_abs > DISP_MAX) ? BCD7_W'(DISP_MAX) : sel_abs[BCD7_W-1:0];
    end

    assign launch = (i_mode == MODE_OUTPUT) && !conv_busy && !conv_start;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            conv_start <= 1'b0;
            req_neg    <= 1'b0;
            disp_bcd   <= '0;
            disp_neg   <= 1'b0;
        end else begin
            conv_start <= launch;
            if (launch) begin
                req_neg <= sel_neg;     // zero is never negative
            end
            if (conv_done) begin
                disp_bcd <= conv_bcd;
                disp_neg <= req_neg;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (launch) begin
            conv_val <= sat_val;
        end
    end

    bin_to_bcd7 u_bcd7 (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_start (conv_start),
        .i_val   (conv_val),
        .o_busy  (conv_busy),
        .o_done  (conv_done),
        .o_bcd7  (conv_bcd)
    );

    // leftmost digit carries the sign, display as +-iiii.fff
    always_comb begin
        if (i_mode == MODE_OUTPUT) begin
            o_bcd8d   = {disp_neg ? CODE_MINUS : CODE_BLANK, disp_bcd};
            o_dp_mask = RESULT_DP_MASK;
        end else begin
            o_bcd8d   = {8{CODE_BLANK}};
            o_dp_mask = '0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/entry/sample_cell.sv
`timescale 1ns/1ps
`default_nettype none

module sample_cell
    import fft_ui_pkg::*;
(
    input  wire logic              i_clk,
    input  wire logic              i_rstn,
    input  wire key_t              i_key,
    input  wire logic              i_sel,
    input  wire logic              i_clear,
    input  wire logic              i_commit,
    output sample_t                o_x
);

    localparam int LEN_W = $clog2(MAX_DIGITS + 1);

    logic                    neg;         // minus toggled
    logic                    dp;          // dot entered
    logic [LEN_W-1:0]        int_len;
    logic [LEN_W-1:0]        frac_len;
    logic [4*MAX_DIGITS-1:0] int_bcd;     // first typed digit at the top
    logic [4*MAX_DIGITS-1:0] frac_bcd;
    logic [SAMPLE_W-2:0]     abs_scaled;
    logic                    key_edit;

    function automatic logic [9:0] bcd3(input logic [3:0] h, input logic [3:0] t,
                                        input logic [3:0] u);
        return 10'(h * 100 + t * 10 + u);
    endfunction

    // integer digits are right aligned by length
    function automatic logic [9:0] int_value(input logic [11:0] bcd, input logic [1:0] len);
        case (len)
            2'd0:    return '0;
            2'd1:    return bcd3(4'd0, 4'd0, bcd[11:8]);
            2'd2:    return bcd3(4'd0, bcd[11:8], bcd[7:4]);
            default: return bcd3(bcd[11:8], bcd[7:4], bcd[3:0]);
        endcase
    endfunction

    // fraction digits are padded with zeros on the right
    function automatic logic [9:0] frac_value(input logic [11:0] bcd, input logic [1:0] len);
        case (len)
            2'd0:    return '0;
            2'd1:    return bcd3(bcd[11:8], 4'd0, 4'd0);
            2'd2:    return bcd3(bcd[11:8], bcd[7:4], 4'd0);
            default: return bcd3(bcd[11:8], bcd[7:4], bcd[3:0]);
        endcase
    endfunction

    assign key_edit   = i_sel && i_key.valid;
    assign abs_scaled = (SAMPLE_W-1)'(int_value(int_bcd, int_len) * SCALE
                                      + frac_value(frac_bcd, frac_len));

    // ------------------------------
    // edit state
    // ------------------------------
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            neg      <= 1'b0;
            dp       <= 1'b0;
            int_len  <= '0;
            frac_len <= '0;
        end else if (i_clear) begin
            neg      <= 1'b0;
            dp       <= 1'b0;
            int_len  <= '0;
            frac_len <= '0;
        end else if (key_edit) begin
            if (i_key.is_digit) begin
                if (!dp && int_len < MAX_DIGITS) begin
                    int_len <= int_len + 1'b1;
                end else if (dp && frac_len < MAX_DIGITS) begin
                    frac_len <= frac_len + 1'b1;
                end
            end else if (i_key.is_minus) begin
                neg <= ~neg;
            end else if (i_key.is_dot) begin
                dp <= 1'b1;
            end else if (i_key.is_del) begin    // fraction, then dot, then integer
                if (frac_len != '0) begin
                    frac_len <= frac_len - 1'b1;
                end else if (dp) begin
                    dp <= 1'b0;
                end else if (int_len != '0) begin
                    int_len <= int_len - 1'b1;
                end
            end
        end
    end

    // digits beyond the length are don't care
    always_ff @(posedge i_clk) begin
        if (key_edit && i_key.is_digit) begin
            if (!dp && int_len < MAX_DIGITS) begin
                int_bcd[4*(MAX_DIGITS-1-int_len) +: 4] <= i_key.digit;
            end else if (dp && frac_len < MAX_DIGITS) begin
                frac_bcd[4*(MAX_DIGITS-1-frac_len) +: 4] <= i_key.digit;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_x <= '0;
        end else if (i_commit) begin
            if (abs_scaled == '0) begin
                o_x <= '0;      // -0 commits as plain 0
            end else begin
                o_x <= neg ? -$signed({1'b0, abs_scaled}) : $signed({1'b0, abs_scaled});
            end
        end
    end

    // a digit on a full part must not wrap its length
    a_len_limit : assert property (@(posedge i_clk) disable iff (!i_rstn)
        (key_edit && i_key.is_digit)
            |=> (int_len >= $past(int_len)) && (frac_len >= $past(frac_len)));

endmodule

`default_nettype wire

//--- rtl/fft_ui_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fft_ui_ctrl
    import fft_ui_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_rstn,
    input  wire key_t        i_key,
    input  wire logic        i_fft_busy,
    input  wire logic        i_fft_done,
    input  wire bins_t       i_x_re,
    input  wire bins_t       i_x_im,
    output logic             o_fft_start,
    output sample_x_t        o_x,
    output logic [31:0]      o_bcd8d,
    output logic [7:0]       o_dp_mask,
    output logic [7:0]       o_index,
    output logic             o_FFT,
    output logic             o_re_im
);

    logic [N_SAMPLES-1:0] edit_sel;
    logic                 clear;
    logic                 commit;
    mode_e                mode;
    logic [IDX_W-1:0]     cur_bin;
    logic                 show_imag;

    ui_mode_ctrl u_mode_ctrl (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_key       (i_key),
        .i_fft_busy  (i_fft_busy),
        .i_fft_done  (i_fft_done),
        .o_edit_sel  (edit_sel),
        .o_clear     (clear),
        .o_commit    (commit),
        .o_fft_start (o_fft_start),
        .o_mode      (mode),
        .o_cur_bin   (cur_bin),
        .o_show_imag (show_imag),
        .o_index     (o_index),
        .o_FFT       (o_FFT),
        .o_re_im     (o_re_im)
    );

    // one cell per sample, each drains to its slice of the FFT input
    for (genvar g = 0; g < N_SAMPLES; g++) begin : g_cell
        sample_cell u_cell (
            .i_clk    (i_clk),
            .i_rstn   (i_rstn),
            .i_key    (i_key),
            .i_sel    (edit_sel[g]),
            .i_clear  (clear),
            .i_commit (commit),
            .o_x      (o_x[g])
        );
    end

    result_display u_display (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_mode      (mode),
        .i_cur_bin   (cur_bin),
        .i_show_imag (show_imag),
        .i_x_re      (i_x_re),
        .i_x_im      (i_x_im),
        .o_bcd8d     (o_bcd8d),
        .o_dp_mask   (o_dp_mask)
    );

endmodule

`default_nettype wire

//--- rtl/ui_mode_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ui_mode_ctrl
    import fft_ui_pkg::*;
(
    input  wire logic              i_clk,
    input  wire logic              i_rstn,
    input  wire key_t              i_key,
    input  wire logic              i_fft_busy,
    input  wire logic              i_fft_done,
    output logic [N_SAMPLES-1:0]   o_edit_sel,
    output logic                   o_clear,
    output logic                   o_commit,
    output logic                   o_fft_start,
    output mode_e                  o_mode,
    output logic [IDX_W-1:0]       o_cur_bin,
    output logic                   o_show_imag,
    output logic [N_SAMPLES-1:0]   o_index,
    output logic                   o_FFT,
    output logic                   o_re_im
);

    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(N_SAMPLES - 1);

    mode_e            mode_q;
    logic [IDX_W-1:0] cur_sample;
    logic [IDX_W-1:0] cur_bin;
    logic             show_imag;
    logic             in_input;

    assign in_input = (mode_q == MODE_INPUT);

    // cells act on these at the very next edge
    assign o_commit   = in_input && i_key.valid && i_key.is_ent && !i_fft_busy;
    assign o_clear    = in_input && i_key.valid && i_key.is_esc;
    assign o_edit_sel = in_input ? (N_SAMPLES'(1) << cur_sample) : '0;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            mode_q      <= MODE_INPUT;
            cur_sample  <= '0;
            cur_bin     <= '0;
            show_imag   <= 1'b0;
            o_fft_start <= 1'b0;
        end else begin
            o_fft_start <= o_commit;    // one cycle after the samples latch
            case (mode_q)
                MODE_INPUT: begin
                    if (o_commit) begin
                        mode_q <= MODE_WAIT_FFT;
                    end else if (o_clear) begin
                        cur_sample <= '0;
                    end else if (i_key.valid && i_key.is_next) begin
                        cur_sample <= (cur_sample == LAST_IDX) ? '0 : cur_sample + 1'b1;
                    end else if (i_key.valid && i_key.is_prev) begin
                        cur_sample <= (cur_sample == '0) ? LAST_IDX : cur_sample - 1'b1;
                    end
                end
                MODE_WAIT_FFT: begin    // keys ignored here
                    if (i_fft_done) begin
                        mode_q    <= MODE_OUTPUT;
                        cur_bin   <= '0;
                        show_imag <= 1'b0;  // start on the real part
                    end
                end
                MODE_OUTPUT: begin
                    if (i_key.valid) begin
                        if (i_key.is_next) begin
                            cur_bin <= (cur_bin == LAST_IDX) ? '0 : cur_bin + 1'b1;
                        end else if (i_key.is_prev) begin
                            cur_bin <= (cur_bin == '0) ? LAST_IDX : cur_bin - 1'b1;
                        end else if (i_key.is_toggle_ri) begin
                            show_imag <= ~show_imag;
                        end else if (i_key.is_esc) begin
                            mode_q     <= MODE_INPUT;   // samples stay stored
                            cur_sample <= '0;
                        end
                    end
                end
                default: mode_q <= MODE_INPUT;
            endcase
        end
    end

    // ------------------------------
    // status and index leds
    // ------------------------------
    assign o_mode      = mode_q;
    assign o_cur_bin   = cur_bin;
    assign o_show_imag = show_imag;
    assign o_FFT       = in_input;
    assign o_re_im     = !((mode_q == MODE_OUTPUT) && show_imag);   // 1 = real
    assign o_index     = ~(N_SAMPLES'(1) << ((mode_q == MODE_OUTPUT) ? cur_bin : cur_sample));

    // the FFT core must see a single-cycle start per accepted enter
    a_start_single : assert property (@(posedge i_clk) disable iff (!i_rstn)
        o_fft_start |=> !o_fft_start);

endmodule

`default_nettype wire

//--- verification/tb_fft_ui_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fft_ui_ctrl
    import fft_ui_pkg::*;
();

    localparam int KEY_EVENTS = 220;    // upper bound on keys pressed in the run
    localparam int K_DIGIT  = 0;
    localparam int K_MINUS  = 1;
    localparam int K_DOT    = 2;
    localparam int K_DEL    = 3;
    localparam int K_NEXT   = 4;
    localparam int K_PREV   = 5;
    localparam int K_TOGGLE = 6;
    localparam int K_ENT    = 7;
    localparam int K_ESC    = 8;

    logic        i_clk;
    logic        i_rstn;
    key_t        i_key;
    logic        i_fft_busy;
    logic        i_fft_done;
    bins_t       i_x_re;
    bins_t       i_x_im;
    logic        o_fft_start;
    sample_x_t   o_x;
    logic [31:0] o_bcd8d;
    logic [7:0]  o_dp_mask;
    logic [7:0]  o_index;
    logic        o_FFT;
    logic        o_re_im;

    logic        core_busy;
    logic        hold_busy;         // forces busy while still in input mode
    logic        check_display;
    int          error_count = 0;
    logic [31:0] lfsr_state = 32'h2b39_0797;

    // keystroke model of the samples
    bit    m_neg      [N_SAMPLES];
    bit    m_dp       [N_SAMPLES];
    int    m_int      [N_SAMPLES];
    int    m_int_len  [N_SAMPLES];
    int    m_frac     [N_SAMPLES];
    int    m_frac_len [N_SAMPLES];
    int    m_idx;
    int    m_bin;
    bit    m_imag;
    mode_e m_mode;

    assign i_fft_busy = core_busy | hold_busy;

    fft_ui_ctrl DUT (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_key       (i_key),
        .i_fft_busy  (i_fft_busy),
        .i_fft_done  (i_fft_done),
        .i_x_re      (i_x_re),
        .i_x_im      (i_x_im),
        .o_fft_start (o_fft_start),
        .o_x         (o_x),
        .o_bcd8d     (o_bcd8d),
        .o_dp_mask   (o_dp_mask),
        .o_index     (o_index),
        .o_FFT       (o_FFT),
        .o_re_im     (o_re_im)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // ------------------------------
    // random numbers and reference
    // ------------------------------
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};   // taps 32 22 2 1
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    function automatic result_t random_bin();
        logic [1:0]  kind;
        logic [31:0] r;
        kind = 2'(rand_bits(2));
        r    = rand_bits(32);
        case (kind)
            2'd0:    return result_t'(r);                 // mostly past DISP_MAX
            2'd1:    return result_t'($signed(r[23:0]));
            2'd2:    return result_t'($signed(r[15:0]));
            default: return '0;
        endcase
    endfunction

    function automatic longint sample_ref(input int i);
        longint mag;
        longint frac;
        frac = m_frac[i];
        for (int k = m_frac_len[i]; k < MAX_DIGITS; k++) begin
            frac = frac * 10;       // pad the fraction on the right
        end
        mag = longint'(m_int[i]) * SCALE + frac;
        if (mag == 0) begin
            return 0;
        end
        return m_neg[i] ? -mag : mag;
    endfunction

    function automatic logic [31:0] display_ref(input result_t v);
        longint      mag;
        logic [31:0] word;
        mag = v;
        if (mag < 0) begin
            mag = -mag;
        end
        if (mag > DISP_MAX) begin
            mag = DISP_MAX;
        end
        word[31:28] = (v < 0) ? CODE_MINUS : CODE_BLANK;
        for (int d = 0; d < 7; d++) begin
            word[4*d +: 4] = 4'(mag % 10);
            mag = mag / 10;
        end
        return word;
    endfunction

    task automatic stop_on_error();
        $display("Test failures found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input longint got, input longint exp);
        assert (got == exp) else begin
            error_count = error_count + 1;
            $display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // compares o_x on each start and the display on request
    always @(negedge i_clk) begin : compare
        result_t shown;
        if (i_rstn && o_fft_start) begin
            for (int i = 0; i < N_SAMPLES; i++) begin
                check_value($sformatf("o_x[%0d]", i), o_x[i], sample_ref(i));
            end
        end
        if (check_display) begin
            shown = m_imag ? i_x_im[m_bin] : i_x_re[m_bin];
            check_value("o_bcd8d", o_bcd8d, display_ref(shown));
            check_value("o_dp_mask", o_dp_mask, RESULT_DP_MASK);
        end
    end

    // ------------------------------
    // fake FFT core
    // ------------------------------
    initial begin : fake_fft_core
        int dur;
        core_busy  = 1'b0;
        i_fft_done = 1'b0;
        i_x_re     = '0;
        i_x_im     = '0;
        forever begin
            @(posedge i_clk);
            if (o_fft_start) begin
                #2;
                core_busy = 1'b1;
                dur = 5 + int'(rand_bits(4));   // 5 to 20 cycles
                for (int b = 0; b < N_SAMPLES; b++) begin
                    i_x_re[b] = random_bin();
                    i_x_im[b] = random_bin();
                end
                repeat (dur) @(posedge i_clk);
                #2;
                core_busy  = 1'b0;
                i_fft_done = 1'b1;
                @(posedge i_clk);
                #2 i_fft_done = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (KEY_EVENTS * 80 + 20000) @(posedge i_clk);
        $display("Timeout: the run took longer than %0d cycles", KEY_EVENTS * 80 + 20000);
        stop_on_error();
    end

    // ------------------------------
    // model and key tasks
    // ------------------------------
    task automatic clear_model();
        for (int i = 0; i < N_SAMPLES; i++) begin
            m_neg[i]      = 1'b0;
            m_dp[i]       = 1'b0;
            m_int[i]      = 0;
            m_int_len[i]  = 0;
            m_frac[i]     = 0;
            m_frac_len[i] = 0;
        end
    endtask

    task automatic update_model(input int kind, input int d);
        case (m_mode)
            MODE_INPUT: begin
                case (kind)
                    K_DIGIT: begin
                        if (!m_dp[m_idx] && m_int_len[m_idx] < MAX_DIGITS) begin
                            m_int[m_idx]     = m_int[m_idx] * 10 + d;
                            m_int_len[m_idx] = m_int_len[m_idx] + 1;
                        end else if (m_dp[m_idx] && m_frac_len[m_idx] < MAX_DIGITS) begin
                            m_frac[m_idx]     = m_frac[m_idx] * 10 + d;
                            m_frac_len[m_idx] = m_frac_len[m_idx] + 1;
                        end
                    end
                    K_MINUS: m_neg[m_idx] = !m_neg[m_idx];
                    K_DOT:   m_dp[m_idx] = 1'b1;
                    K_DEL: begin
                        if (m_frac_len[m_idx] > 0) begin
                            m_frac[m_idx]     = m_frac[m_idx] / 10;
                            m_frac_len[m_idx] = m_frac_len[m_idx] - 1;
                        end else if (m_dp[m_idx]) begin
                            m_dp[m_idx] = 1'b0;
                        end else if (m_int_len[m_idx] > 0) begin
                            m_int[m_idx]     = m_int[m_idx] / 10;
                            m_int_len[m_idx] = m_int_len[m_idx] - 1;
                        end
                    end
                    K_NEXT: m_idx = (m_idx + 1) % N_SAMPLES;
                    K_PREV: m_idx = (m_idx + N_SAMPLES - 1) % N_SAMPLES;
                    K_ENT: begin
                        if (!hold_busy) begin
                            m_mode = MODE_WAIT_FFT;
                        end
                    end
                    K_ESC: begin
                        clear_model();
                        m_idx = 0;
                    end
                    default: ;
                endcase
            end
            MODE_OUTPUT: begin
                case (kind)
                    K_NEXT:   m_bin = (m_bin + 1) % N_SAMPLES;
                    K_PREV:   m_bin = (m_bin + N_SAMPLES - 1) % N_SAMPLES;
                    K_TOGGLE: m_imag = !m_imag;
                    K_ESC: begin
                        m_mode = MODE_INPUT;    // samples are kept
                        m_idx  = 0;
                    end
                    default: ;
                endcase
            end
            default: ;  // keys do nothing while the FFT runs
        endcase
    endtask

    function automatic key_t make_key(input int kind, input int d);
        key_t k;
        k       = '0;
        k.valid = 1'b1;
        case (kind)
            K_DIGIT: begin
                k.is_digit = 1'b1;
                k.digit    = 4'(d);
            end
            K_MINUS:  k.is_minus     = 1'b1;
            K_DOT:    k.is_dot       = 1'b1;
            K_DEL:    k.is_del       = 1'b1;
            K_NEXT:   k.is_next      = 1'b1;
            K_PREV:   k.is_prev      = 1'b1;
            K_TOGGLE: k.is_toggle_ri = 1'b1;
            K_ENT:    k.is_ent       = 1'b1;
            default:  k.is_esc       = 1'b1;
        endcase
        return k;
    endfunction

    task automatic tick();
        @(posedge i_clk);
        #2;
    endtask

    task automatic check_status();
        logic [7:0] leds;
        leds = ~(8'd1 << ((m_mode == MODE_OUTPUT) ? m_bin : m_idx));
        check_value("o_index", o_index, leds);
        check_value("o_FFT", o_FFT, m_mode == MODE_INPUT);
        check_value("o_re_im", o_re_im, !(m_mode == MODE_OUTPUT && m_imag));
    endtask

    // one key for one cycle, then the flags are checked
    task automatic press(input int kind, input int d);
        update_model(kind, d);
        i_key = make_key(kind, d);
        tick();
        i_key = '0;
        check_status();
    endtask

    task automatic type_text(input string s);
        byte c;
        for (int i = 0; i < s.len(); i++) begin
            c = s[i];
            case (c)
                "-":     press(K_MINUS, 0);
                ".":     press(K_DOT, 0);
                "<":     press(K_DEL, 0);
                ">":     press(K_NEXT, 0);
                default: press(K_DIGIT, int'(c) - 48);
            endcase
        end
    endtask

    task automatic check_bin_display();
        repeat (64) tick();
        check_display = 1'b1;
        tick();
        check_display = 1'b0;
    endtask

    // ------------------------------
    // test sequences
    // ------------------------------
    task automatic random_entry();
        int         n;
        logic [2:0] pick;
        for (int s = 0; s < N_SAMPLES; s++) begin
            n = 4 + int'(rand_bits(3));
            for (int k = 0; k < n; k++) begin
                pick = 3'(rand_bits(3));
                if (pick == 3'd6) begin
                    press(K_DOT, 0);
                end else if (pick == 3'd7) begin
                    press(K_MINUS, 0);
                end else begin
                    press(K_DIGIT, int'(rand_bits(4)) % 10);
                end
            end
            press(K_NEXT, 0);   // wraps to 0 after the last sample
        end
    endtask

    task automatic run_fft();
        int n;
        press(K_ENT, 0);
        n = 0;
        while (!o_fft_start) begin
            if (n == 10) begin
                $display("Enter was accepted but no start pulse reached the FFT core");
                stop_on_error();
            end
            tick();
            n = n + 1;
        end
        press(K_NEXT, 0);   // ignored while waiting
        check_value("o_fft_start", o_fft_start, 0);
        press(K_DIGIT, 9);
        press(K_MINUS, 0);
        n = 0;
        while (o_dp_mask != RESULT_DP_MASK) begin
            if (n == 40) begin
                $display("The result display did not come up after the FFT core was done");
                stop_on_error();
            end
            tick();
            n = n + 1;
        end
        m_mode = MODE_OUTPUT;
        m_bin  = 0;
        m_imag = 1'b0;
        check_status();
        check_bin_display();
    endtask

    task automatic browse_bins(input int n);
        logic [1:0] pick;
        press(K_PREV, 0);   // 0 -> 7
        check_bin_display();
        press(K_NEXT, 0);   // 7 -> 0
        check_bin_display();
        for (int k = 0; k < n; k++) begin
            pick = 2'(rand_bits(2));
            case (pick)
                2'd0:    press(K_NEXT, 0);
                2'd1:    press(K_PREV, 0);
                default: press(K_TOGGLE, 0);
            endcase
            check_bin_display();
        end
    endtask

    task automatic leave_output();
        press(K_ESC, 0);
        check_value("o_bcd8d", o_bcd8d, 32'hBBBB_BBBB);
        check_value("o_dp_mask", o_dp_mask, 0);
    endtask

    task automatic enter_while_busy();
        hold_busy = 1'b1;
        press(K_ENT, 0);
        repeat (3) begin
            check_value("o_fft_start", o_fft_start, 0);
            tick();
        end
        hold_busy = 1'b0;
    endtask

    initial begin : stimulus
        i_rstn        = 1'b0;
        i_key         = '0;
        hold_busy     = 1'b0;
        check_display = 1'b0;
        m_mode        = MODE_INPUT;
        m_idx         = 0;
        m_bin         = 0;
        m_imag        = 1'b0;
        clear_model();
        repeat (8) @(posedge i_clk);
        #2;
        i_rstn = 1'b1;

        check_value("o_fft_start", o_fft_start, 0);
        check_value("o_bcd8d", o_bcd8d, 32'hBBBB_BBBB);
        check_value("o_dp_mask", o_dp_mask, 0);
        check_status();

        random_entry();
        run_fft();
        browse_bins(10);
        leave_output();
        run_fft();          // same samples again
        browse_bins(3);
        leave_output();

        // index 6, then escape back to 0 with everything cleared
        press(K_PREV, 0);
        press(K_PREV, 0);
        press(K_ESC, 0);
        type_text("12.34<<<<5->-0.00>-<7>--4.5>98765.43210");
        enter_while_busy();
        run_fft();
        browse_bins(3);
        leave_output();

        if (error_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_on_error();
        end
    end

endmodule

`default_nettype wire
